//--- tb.f
+incdir+include
source/speed_test_axi_pkg.sv
source/speed_test_ctrl_pkg.sv
source/speed_test_axi_slave.sv
source/speed_test_regs.sv
source/speed_test_sequencer.sv
source/speed_test_controller.sv
verification/speed_test_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module speed_test_tb \
    -o speed_test_sim || { echo "build failed"; exit 1; }

./obj_dir/speed_test_sim > sim.log 2>&1 ; cat sim.log

[ -s sim.log ] || { echo "no simulation log"; exit 1; }
grep -q "Regression failed" sim.log && exit 1 || exit 0

//--- verification/speed_test_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "speed_test_cfg.svh"

module speed_test_tb;
    import speed_test_axi_pkg::*;
    import speed_test_ctrl_pkg::*;

    localparam int TEST_NUM = 3;
    localparam int CFG_NUM  = 12;
    // longest test is 6 ms plus drain plus bus overhead per test
    localparam int LIMIT_NS = TEST_NUM * ((6 + `WAIT_MS_AFTER_STOP) * `CYCLES_PER_MS + 80) * 4
                              + 3000;

    logic                              S_AXI_ACLK = 1'b0;
    logic                              S_AXI_ARESETN;
    axi_addr_t                         s_axi_awaddr;
    logic                              s_axi_awvalid;
    logic                              s_axi_awready;
    axi_data_t                         s_axi_wdata;
    axi_strb_t                         s_axi_wstrb;
    logic                              s_axi_wvalid;
    logic                              s_axi_wready;
    axi_resp_e                         s_axi_bresp;
    logic                              s_axi_bvalid;
    logic                              s_axi_bready;
    axi_addr_t                         s_axi_araddr;
    logic                              s_axi_arvalid;
    logic                              s_axi_arready;
    axi_data_t                         s_axi_rdata;
    axi_resp_e                         s_axi_rresp;
    logic                              s_axi_rvalid;
    logic                              s_axi_rready;
    logic [`TEST_PORT_NUM-1:0]         gen_ready;
    logic [`TEST_PORT_NUM-1:0]         check_ready;
    port_result_t [`TEST_PORT_NUM-1:0] check_results;
    logic [`TEST_PORT_NUM-1:0]         start;
    logic [`TEST_PORT_NUM-1:0]         stop;
    port_config_t [`TEST_PORT_NUM-1:0] port_config;

    // shadow of the register map as software should see it
    port_config_t shadow_cfg [`TEST_PORT_NUM];
    port_result_t shadow_res [`TEST_PORT_NUM];
    logic         exp_busy;
    ms_t          exp_test_ms;
    ms_t          exp_wait_ms;

    // pending checks drained by the comparing process
    axi_data_t got_q [$];
    axi_data_t exp_q [$];
    string     what_q [$];

    // pulse monitor state
    int   cycle = 0;
    int   start_count = 0;
    int   stop_count = 0;
    int   start_cycle = 0;
    int   stop_cycle = 0;
    logic start_prev = 1'b0;
    logic stop_prev = 1'b0;

    logic [15:0] lfsr_state = 16'd33;

    speed_test_controller u_speed_test_controller (.*);

    always #2 S_AXI_ACLK = ~S_AXI_ACLK;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per returned bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // byte lanes with strobe set take the new data
    function automatic axi_data_t merge_strobe(input axi_data_t old, input axi_data_t data,
                                               input axi_strb_t strb);
        axi_data_t m;
        m = old;
        for (int b = 0; b < `AXI_DATA_WIDTH / 8; b++)
        begin
            if (strb[b])
                m[8*b +: 8] = data[8*b +: 8];
        end
        return m;
    endfunction

    // expected read data from the shadow map
    function automatic axi_data_t ref_read(input axi_addr_t addr);
        axi_data_t d;
        int        idx;
        d = '0;
        if (addr == REG_STATUS)
            d = {31'd0, exp_busy};
        else if (addr == REG_TIME)
            d = {exp_wait_ms, exp_test_ms};
        else if (addr[1:0] == 2'b00)
        begin
            idx = (int'(addr) - int'(REG_CONFIG_BASE)) / 4;
            if (idx >= 0 && idx < `TEST_PORT_NUM)
                d = shadow_cfg[idx];
            idx = (int'(addr) - int'(REG_RESULT_BASE)) / 4;
            if (idx >= 0 && idx < `TEST_PORT_NUM)
                d = shadow_res[idx];
        end
        return d;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic push_check(input axi_data_t got, input axi_data_t exp, input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // called on a rising edge and returns on the B handshake edge
    task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
        int delay;
        delay = int'(random_bits(2));
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_wvalid  <= 1'b1;
        @(posedge S_AXI_ACLK);
        while (!s_axi_awready)
            @(posedge S_AXI_ACLK);
        // W is taken on the same edge as AW
        push_check(axi_data_t'(s_axi_wready), axi_data_t'(1'b1), "wready with awready");
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        // hold off BREADY a random number of cycles
        repeat (delay) @(posedge S_AXI_ACLK);
        s_axi_bready <= 1'b1;
        @(posedge S_AXI_ACLK);
        while (!s_axi_bvalid)
            @(posedge S_AXI_ACLK);
        s_axi_bready <= 1'b0;
        push_check(axi_data_t'(s_axi_bresp), axi_data_t'(OKAY), "bresp");
    endtask

    // expected value is taken when the read is issued
    task automatic axi_read(input axi_addr_t addr);
        int        delay;
        axi_data_t exp;
        delay = int'(random_bits(2));
        exp = ref_read(addr);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        @(posedge S_AXI_ACLK);
        while (!s_axi_arready)
            @(posedge S_AXI_ACLK);
        s_axi_arvalid <= 1'b0;
        repeat (delay) @(posedge S_AXI_ACLK);
        s_axi_rready <= 1'b1;
        @(posedge S_AXI_ACLK);
        while (!s_axi_rvalid)
            @(posedge S_AXI_ACLK);
        s_axi_rready <= 1'b0;
        push_check(s_axi_rdata, exp, $sformatf("read of %h", addr));
        push_check(axi_data_t'(s_axi_rresp), axi_data_t'(OKAY), "rresp");
    endtask

    // comparing process
    always @(posedge S_AXI_ACLK)
    begin : compare
        axi_data_t got;
        axi_data_t exp;
        string     what;
        while (got_q.size() > 0)
        begin
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            what = what_q.pop_front();
            assert (got == exp)
            else
                report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    end

    // start and stop are equal on all ports and each pulse lasts one cycle
    always @(posedge S_AXI_ACLK)
    begin
        cycle <= cycle + 1;
        if (S_AXI_ARESETN)
        begin
            assert ((start == '0 || start == '1) && (stop == '0 || stop == '1))
            else
                report_mismatch($sformatf("ports disagree, start %b stop %b", start, stop));
            assert (!(start[0] && start_prev) && !(stop[0] && stop_prev))
            else
                report_mismatch("start or stop held longer than one cycle");
            if (start[0])
            begin
                start_count <= start_count + 1;
                start_cycle <= cycle;
            end
            if (stop[0])
            begin
                stop_count <= stop_count + 1;
                stop_cycle <= cycle;
            end
            start_prev <= start[0];
            stop_prev  <= stop[0];
        end
    end

    initial
    begin
        #(LIMIT_NS);
        $display("timeout: the test sequence did not finish within %0d ns", LIMIT_NS);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int        dur;
        int        p;
        axi_data_t d;
        axi_strb_t s;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        gen_ready     = '0;
        check_ready   = '0;
        check_results = '0;
        exp_busy      = 1'b1;
        exp_test_ms   = '0;
        exp_wait_ms   = '0;
        for (int i = 0; i < `TEST_PORT_NUM; i++)
        begin
            shadow_cfg[i] = '0;
            shadow_res[i] = '0;
        end
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;

        // busy stays up until every generator and checker is ready
        axi_read(REG_STATUS);
        gen_ready   <= '1;
        check_ready <= 4'b1011;
        repeat (3) @(posedge S_AXI_ACLK);
        axi_read(REG_STATUS);
        check_ready <= '1;
        repeat (3) @(posedge S_AXI_ACLK);
        exp_busy = 1'b0;
        axi_read(REG_STATUS);

        // strobed config writes, bus readback and port outputs
        for (int i = 0; i < CFG_NUM; i++)
        begin
            p = int'(random_bits(2));
            d = random_bits(32);
            s = axi_strb_t'(random_bits(4));
            axi_write(axi_addr_t'(REG_CONFIG_BASE + 4 * p), d, s);
            shadow_cfg[p] = merge_strobe(shadow_cfg[p], d, s);
            push_check(port_config[p], shadow_cfg[p], $sformatf("port_config[%0d]", p));
            axi_read(axi_addr_t'(REG_CONFIG_BASE + 4 * p));
        end
        // unmapped and write-only locations read zero
        axi_read(axi_addr_t'(9'h0C0));
        axi_read(REG_START);

        // zero low byte or missing lane 0 strobe must not start
        axi_write(REG_START, 32'h0000_0000, 4'hF);
        axi_write(REG_START, 32'h0000_00FF, 4'hE);
        axi_read(REG_STATUS);

        for (int t = 0; t < TEST_NUM; t++)
        begin
            dur = 1 + int'(random_bits(3)) % 6;
            axi_write(REG_TIME, axi_data_t'(dur), 4'h3);
            check_results <= '0;
            for (int i = 0; i < `TEST_PORT_NUM; i++)
                shadow_res[i] = '0;
            axi_write(REG_START, 32'h0000_0001, 4'h1);
            exp_busy = 1'b1;
            // a second start while running is ignored
            axi_write(REG_START, 32'h0000_0001, 4'h1);
            axi_read(REG_STATUS);
            // results were cleared by the start
            axi_read(REG_RESULT_BASE);
            while (stop_count != t + 1)
                @(posedge S_AXI_ACLK);
            // checker values stay constant through the drain
            for (int i = 0; i < `TEST_PORT_NUM; i++)
            begin
                d = random_bits(32);
                check_results[i] <= d;
                shadow_res[i] = d;
            end
            push_check(axi_data_t'(stop_cycle - start_cycle),
                       axi_data_t'(dur * `CYCLES_PER_MS), "cycles from start to stop");
            repeat (`WAIT_MS_AFTER_STOP * `CYCLES_PER_MS + 4) @(posedge S_AXI_ACLK);
            push_check(axi_data_t'(start_count), axi_data_t'(t + 1), "start pulse count");
            exp_busy    = 1'b0;
            exp_test_ms = ms_t'(dur);
            exp_wait_ms = ms_t'(`WAIT_MS_AFTER_STOP);
            axi_read(REG_TIME);
            axi_read(REG_STATUS);
            for (int i = 0; i < `TEST_PORT_NUM; i++)
                axi_read(axi_addr_t'(REG_RESULT_BASE + 4 * i));
        end

        while (got_q.size() != 0)
            @(posedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/speed_test_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "speed_test_cfg.svh"

module speed_test_controller (
    input  wire                                S_AXI_ACLK,
    input  wire                                S_AXI_ARESETN,
    input  wire speed_test_axi_pkg::axi_addr_t s_axi_awaddr,
    input  wire                                s_axi_awvalid,
    output logic                               s_axi_awready,
    input  wire speed_test_axi_pkg::axi_data_t s_axi_wdata,
    input  wire speed_test_axi_pkg::axi_strb_t s_axi_wstrb,
    input  wire                                s_axi_wvalid,
    output logic                               s_axi_wready,
    output speed_test_axi_pkg::axi_resp_e      s_axi_bresp,
    output logic                               s_axi_bvalid,
    input  wire                                s_axi_bready,
    input  wire speed_test_axi_pkg::axi_addr_t s_axi_araddr,
    input  wire                                s_axi_arvalid,
    output logic                               s_axi_arready,
    output speed_test_axi_pkg::axi_data_t      s_axi_rdata,
    output speed_test_axi_pkg::axi_resp_e      s_axi_rresp,
    output logic                               s_axi_rvalid,
    input  wire                                s_axi_rready,
    input  wire [`TEST_PORT_NUM-1:0]           gen_ready,
    input  wire [`TEST_PORT_NUM-1:0]           check_ready,
    input  wire speed_test_ctrl_pkg::port_result_t [`TEST_PORT_NUM-1:0] check_results,
    output logic [`TEST_PORT_NUM-1:0]          start,
    output logic [`TEST_PORT_NUM-1:0]          stop,
    output speed_test_ctrl_pkg::port_config_t [`TEST_PORT_NUM-1:0] port_config
);
    import speed_test_axi_pkg::*;
    import speed_test_ctrl_pkg::*;

    // bus front end to register bank
    logic      wr_en;
    axi_addr_t wr_addr;
    axi_data_t wr_data;
    axi_strb_t wr_strb;
    logic      rd_en;
    axi_addr_t rd_addr;
    axi_data_t rd_data;

    // register bank and sequencer
    logic      start_req;
    duration_t duration;
    logic      busy;
    ms_t       test_ms;
    ms_t       wait_ms;
    logic      results_clr;
    logic      results_en;
    logic      test_start;
    logic      test_stop;

    speed_test_axi_slave u_axi_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    speed_test_regs u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .start_req     (start_req),
        .duration      (duration),
        .port_config   (port_config),
        .busy          (busy),
        .test_ms       (test_ms),
        .wait_ms       (wait_ms),
        .results_clr   (results_clr),
        .results_en    (results_en),
        .check_results (check_results)
    );

    speed_test_sequencer u_sequencer (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen_ready     (gen_ready),
        .check_ready   (check_ready),
        .start_req     (start_req),
        .duration      (duration),
        .busy          (busy),
        .test_start    (test_start),
        .test_stop     (test_stop),
        .test_ms       (test_ms),
        .wait_ms       (wait_ms),
        .results_clr   (results_clr),
        .results_en    (results_en)
    );

    // every port starts and stops on the same cycle
    assign start = {`TEST_PORT_NUM{test_start}};
    assign stop  = {`TEST_PORT_NUM{test_stop}};

endmodule

`default_nettype wire

//--- source/speed_test_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "speed_test_cfg.svh"

module speed_test_sequencer (
    input  wire                                 S_AXI_ACLK,
    input  wire                                 S_AXI_ARESETN,
    input  wire [`TEST_PORT_NUM-1:0]            gen_ready,
    input  wire [`TEST_PORT_NUM-1:0]            check_ready,
    input  wire                                 start_req,
    input  wire speed_test_ctrl_pkg::duration_t duration,
    output logic                                busy,
    output logic                                test_start,
    output logic                                test_stop,
    output speed_test_ctrl_pkg::ms_t            test_ms,
    output speed_test_ctrl_pkg::ms_t            wait_ms,
    output logic                                results_clr,
    output logic                                results_en
);
    import speed_test_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`CYCLES_PER_MS + 1);

    ctrl_state_e      state;
    logic [CNT_W-1:0] cycle_cnt;
    logic             ms_tick;
    logic             all_ready;
    logic             start_ok;
    ms_t              test_ms_inc;
    ms_t              wait_ms_inc;

    assign all_ready = (&gen_ready) && (&check_ready);
    // start only counts between tests
    assign start_ok = (state == IDLE) && start_req;
    // last cycle of the current millisecond
    assign ms_tick = (cycle_cnt == CNT_W'(`CYCLES_PER_MS - 1));
    assign test_ms_inc = test_ms + ms_t'(1);
    assign wait_ms_inc = wait_ms + ms_t'(1);

    assign busy        = (state != IDLE);
    assign results_clr = start_ok;
    assign results_en  = (state == RUNNING) || (state == STOPPING);

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state      <= WAIT;
            test_start <= 1'b0;
            test_stop  <= 1'b0;
            test_ms    <= '0;
            wait_ms    <= '0;
            cycle_cnt  <= '0;
        end
        else
        begin
            // start and stop are single-cycle pulses
            test_start <= 1'b0;
            test_stop  <= 1'b0;
            case (state)
                WAIT:
                begin
                    if (all_ready)
                        state <= IDLE;
                end
                IDLE:
                begin
                    if (start_ok)
                    begin
                        test_start <= 1'b1;
                        test_ms    <= '0;
                        wait_ms    <= '0;
                        cycle_cnt  <= '0;
                        state      <= RUNNING;
                    end
                end
                RUNNING:
                begin
                    cycle_cnt <= ms_tick ? '0 : cycle_cnt + 1'b1;
                    if (ms_tick)
                    begin
                        test_ms <= test_ms_inc;
                        // stop lands exactly duration ms after start
                        if (test_ms_inc == ms_t'(duration))
                        begin
                            test_stop <= 1'b1;
                            state     <= STOPPING;
                        end
                    end
                end
                STOPPING:
                begin
                    // frames still in flight reach the checkers here
                    cycle_cnt <= ms_tick ? '0 : cycle_cnt + 1'b1;
                    if (ms_tick)
                    begin
                        wait_ms <= wait_ms_inc;
                        if (wait_ms_inc == ms_t'(`WAIT_MS_AFTER_STOP))
                            state <= WAIT;
                    end
                end
                default:
                    state <= WAIT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/speed_test_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "speed_test_cfg.svh"

module speed_test_regs (
    input  wire                                   S_AXI_ACLK,
    input  wire                                   S_AXI_ARESETN,
    input  wire                                   wr_en,
    input  wire speed_test_axi_pkg::axi_addr_t    wr_addr,
    input  wire speed_test_axi_pkg::axi_data_t    wr_data,
    input  wire speed_test_axi_pkg::axi_strb_t    wr_strb,
    input  wire                                   rd_en,
    input  wire speed_test_axi_pkg::axi_addr_t    rd_addr,
    output speed_test_axi_pkg::axi_data_t         rd_data,
    output logic                                  start_req,
    output speed_test_ctrl_pkg::duration_t        duration,
    output speed_test_ctrl_pkg::port_config_t [`TEST_PORT_NUM-1:0] port_config,
    input  wire                                   busy,
    input  wire speed_test_ctrl_pkg::ms_t         test_ms,
    input  wire speed_test_ctrl_pkg::ms_t         wait_ms,
    input  wire                                   results_clr,
    input  wire                                   results_en,
    input  wire speed_test_ctrl_pkg::port_result_t [`TEST_PORT_NUM-1:0] check_results
);
    import speed_test_axi_pkg::*;
    import speed_test_ctrl_pkg::*;

    // captured checker words, one per port
    port_result_t [`TEST_PORT_NUM-1:0] results_q;

    // start is a write-only command
    // any nonzero low byte counts, the sequencer decides if it is taken
    assign start_req = wr_en && (wr_addr == REG_START) && wr_strb[0] && (|wr_data[7:0]);

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            duration    <= '0;
            port_config <= '0;
        end
        else if (wr_en)
        begin
            // duration lives in the low 13 bits of REG_TIME
            if (wr_addr == REG_TIME)
            begin
                if (wr_strb[0])
                    duration[7:0] <= wr_data[7:0];
                if (wr_strb[1])
                    duration[12:8] <= wr_data[12:8];
            end
            // per-port config words, byte lanes follow the strobe
            for (int p = 0; p < `TEST_PORT_NUM; p++)
            begin
                if (wr_addr == axi_addr_t'(REG_CONFIG_BASE + 4 * p))
                begin
                    for (int b = 0; b < `AXI_DATA_WIDTH / 8; b++)
                    begin
                        if (wr_strb[b])
                            port_config[p][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // result capture
    // clear on test start, then follow the checkers until the drain ends
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
            results_q <= '0;
        else if (results_clr)
            results_q <= '0;
        else if (results_en)
            results_q <= check_results;
    end

    // read mux, only opened during a read access
    always_comb
    begin
        rd_data = '0;
        if (rd_en)
        begin
            if (rd_addr == REG_STATUS)
                rd_data = axi_data_t'(busy);
            // drain time on top, test time below
            if (rd_addr == REG_TIME)
                rd_data = {wait_ms, test_ms};
            for (int p = 0; p < `TEST_PORT_NUM; p++)
            begin
                if (rd_addr == axi_addr_t'(REG_CONFIG_BASE + 4 * p))
                    rd_data = port_config[p];
                if (rd_addr == axi_addr_t'(REG_RESULT_BASE + 4 * p))
                    rd_data = results_q[p];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/speed_test_axi_slave.sv
`timescale 1ns/100ps
`default_nettype none

module speed_test_axi_slave (
    input  wire                             S_AXI_ACLK,
    input  wire                             S_AXI_ARESETN,
    input  wire speed_test_axi_pkg::axi_addr_t s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    output logic                            s_axi_awready,
    input  wire speed_test_axi_pkg::axi_data_t s_axi_wdata,
    input  wire speed_test_axi_pkg::axi_strb_t s_axi_wstrb,
    input  wire                             s_axi_wvalid,
    output logic                            s_axi_wready,
    output speed_test_axi_pkg::axi_resp_e   s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  wire                             s_axi_bready,
    input  wire speed_test_axi_pkg::axi_addr_t s_axi_araddr,
    input  wire                             s_axi_arvalid,
    output logic                            s_axi_arready,
    output speed_test_axi_pkg::axi_data_t   s_axi_rdata,
    output speed_test_axi_pkg::axi_resp_e   s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  wire                             s_axi_rready,
    output logic                            wr_en,
    output speed_test_axi_pkg::axi_addr_t   wr_addr,
    output speed_test_axi_pkg::axi_data_t   wr_data,
    output speed_test_axi_pkg::axi_strb_t   wr_strb,
    output logic                            rd_en,
    output speed_test_axi_pkg::axi_addr_t   rd_addr,
    input  wire speed_test_axi_pkg::axi_data_t rd_data
);
    import speed_test_axi_pkg::*;

    // AW and W are taken together, one flop drives both readies
    logic      wr_ready_q;
    logic      ar_ready_q;
    logic      bvalid_q;
    logic      rvalid_q;
    axi_addr_t awaddr_q;
    axi_addr_t araddr_q;
    axi_data_t rdata_q;
    logic      wr_accept;
    logic      ar_accept;

    // only one write in flight, an unacknowledged B blocks the next one
    assign wr_accept = !wr_ready_q && s_axi_awvalid && s_axi_wvalid && !bvalid_q;
    // likewise a pending R blocks the next address
    assign ar_accept = !ar_ready_q && s_axi_arvalid && !rvalid_q;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wr_ready_q <= 1'b0;
            ar_ready_q <= 1'b0;
        end
        else
        begin
            // ready is a single-cycle pulse
            wr_ready_q <= wr_accept;
            ar_ready_q <= ar_accept;
        end
    end

    // address is sampled on the same edge that raises ready
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_accept)
            awaddr_q <= s_axi_awaddr;
        if (ar_accept)
            araddr_q <= s_axi_araddr;
    end

    // access pulses toward the register bank
    // master still holds valid while ready is high, so these last one cycle
    assign wr_en   = wr_ready_q && s_axi_awvalid && s_axi_wvalid;
    assign wr_addr = awaddr_q;
    assign wr_data = s_axi_wdata;
    assign wr_strb = s_axi_wstrb;
    assign rd_en   = ar_ready_q && s_axi_arvalid && !rvalid_q;
    assign rd_addr = araddr_q;

    // response channels
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            if (wr_en)
                bvalid_q <= 1'b1;
            else if (s_axi_bready)
                bvalid_q <= 1'b0;
            if (rd_en)
                rvalid_q <= 1'b1;
            else if (s_axi_rready)
                rvalid_q <= 1'b0;
        end
    end

    // read word is frozen until the master takes it
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_en)
            rdata_q <= rd_data;
    end

    assign s_axi_awready = wr_ready_q;
    assign s_axi_wready  = wr_ready_q;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_bresp   = OKAY;
    assign s_axi_arready = ar_ready_q;
    assign s_axi_rvalid  = rvalid_q;
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = OKAY;

endmodule

`default_nettype wire

//--- source/speed_test_ctrl_pkg.sv
`default_nettype none

`include "speed_test_cfg.svh"

package speed_test_ctrl_pkg;

    // sequencer states
    // WAIT holds until every generator and checker is ready
    typedef enum logic [1:0] {
        WAIT,
        IDLE,
        RUNNING,
        STOPPING
    } ctrl_state_e;

    // register map, byte addresses
    typedef enum logic [`AXI_ADDR_WIDTH-1:0] {
        REG_STATUS      = 9'h000,
        REG_START       = 9'h004,
        REG_TIME        = 9'h008,
        REG_CONFIG_BASE = 9'h100,
        REG_RESULT_BASE = 9'h180
    } reg_addr_e;

    // elapsed milliseconds, test or drain
    typedef logic [15:0] ms_t;

    // programmed test length in ms
    typedef logic [12:0] duration_t;

    // one word per port in each direction
    typedef logic [`AXI_DATA_WIDTH-1:0] port_config_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] port_result_t;

endpackage

`default_nettype wire

//--- source/speed_test_axi_pkg.sv
`default_nettype none

`include "speed_test_cfg.svh"

package speed_test_axi_pkg;

    // byte address on AW and AR
    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;

    // one bus word on W and R
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

    // one strobe bit per data byte
    typedef logic [`AXI_DATA_WIDTH/8-1:0] axi_strb_t;

    // BRESP / RRESP encoding
    // only OKAY goes out, SLVERR is kept for completeness
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

`default_nettype wire

//--- include/speed_test_cfg.svh
`ifndef SPEED_TEST_CFG_SVH
`define SPEED_TEST_CFG_SVH

// number of frame generator and checker pairs under test
`define TEST_PORT_NUM 4

// byte address width of the register window, 512 bytes
`define AXI_ADDR_WIDTH 9

// AXI4-Lite data bus width
`define AXI_DATA_WIDTH 32

// clock cycles per millisecond
// kept tiny so a simulated test finishes in a few hundred cycles
`define CYCLES_PER_MS 10

// checkers keep reporting this many ms after stop
`define WAIT_MS_AFTER_STOP 2

`endif
